/* common/cdc_fifo_pkg.sv */
/*
 * data path types of the clock domain crossing FIFO
 * the payload is a fixed 20-bit word of data and tag
 * the defaults below only seed the top level parameters
 */
package cdc_fifo_pkg;

  // one word as it travels from the source port to the destination port
  typedef struct packed {
    // user data carried by the word
    logic [15:0] data;
    // small side-band label that travels with the data
    logic [3:0]  tag;
  } payload_t;

  // the FIFO holds 2**LOG_DEPTH words
  localparam int LOG_DEPTH_DEFAULT = 3;

  // flop stages on every pointer and handshake crossing
  localparam int SYNC_STAGES_DEFAULT = 2;

endpackage

/* common/cdc_clear_pkg.sv */
/*
 * types of the two-domain clear sequencer
 * the phase encoding is a gray sequence so that a phase can be synchronized
 * into the other clock domain as a plain two-bit level
 */
package cdc_clear_pkg;

  // idle, isolate, clear and release follow each other in this order
  // and every step flips exactly one bit
  typedef enum logic [1:0] {
    PHASE_IDLE    = 2'b00,
    PHASE_ISOLATE = 2'b01,
    PHASE_CLEAR   = 2'b11,
    PHASE_RELEASE = 2'b10
  } clear_phase_e;

  // control that the sequencer hands to one FIFO half
  typedef struct packed {
    // the half stops all handshakes on its port
    logic isolate;
    // the half resets its pointers (and the spill register on the destination side)
    logic clear;
  } clear_ctrl_t;

endpackage

/* verilog/cdc_sync_bits.sv */
/*
 * flop-chain synchronizer, one chain per bit
 * bits are sampled independently, so a multi-bit input must change in one bit
 * at a time (gray pointer or gray phase). STAGES must be at least 2
 */
module cdc_sync_bits #(
  parameter int STAGES = 2,
  parameter int WIDTH  = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [WIDTH-1:0] async_i,
  output logic [WIDTH-1:0] sync_o
);

  // stage 0 is the first flop and may go metastable
  logic [STAGES-1:0][WIDTH-1:0] chain_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chain_q <= '0;
    end else begin
      // shift the whole word one stage further each cycle
      chain_q <= {chain_q[STAGES-2:0], async_i};
    end
  end

  // the last stage is considered settled
  assign sync_o = chain_q[STAGES-1];

endmodule

/* verilog/spill_register_flushable.sv */
/*
 * two-entry spill register with valid/ready on both sides
 * ready_o depends only on the entry state and never on ready_i
 * flush_i drops both entries in the same cycle and blocks a new fill
 */
module spill_register_flushable (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  input  cdc_fifo_pkg::payload_t data_i,
  output logic                   valid_o,
  input  logic                   ready_i,
  output cdc_fifo_pkg::payload_t data_o
);

  // entry a takes new words and entry b holds a word that the output refused
  cdc_fifo_pkg::payload_t a_data_q;
  cdc_fifo_pkg::payload_t b_data_q;
  logic                   a_full_q;
  logic                   b_full_q;
  logic                   a_fill;
  logic                   a_drain;
  logic                   b_fill;
  logic                   b_drain;

  // a word is accepted whenever at least one entry is free
  assign ready_o = ~a_full_q | ~b_full_q;
  assign a_fill  = valid_i & ready_o & ~flush_i;

  // entry a empties when b is free, either to the output or into b
  assign a_drain = (a_full_q & ~b_full_q) | flush_i;
  // the word moves into b only if the output does not take it now
  assign b_fill  = a_drain & ~ready_i & ~flush_i;
  assign b_drain = (b_full_q & ready_i) | flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // b always holds the older word when both entries are full
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

/* cdc_fifo/cdc_fifo_src.sv */
/*
 * source half of the clock domain crossing FIFO, clocked by src_clk_i
 * the storage array and the gray write pointer leave this module unsynchronized
 * full is judged against the delayed read pointer and is therefore pessimistic
 * LOG_DEPTH must be at least 1 and SYNC_STAGES at least 2
 */
module cdc_fifo_src #(
  parameter int LOG_DEPTH   = 3,
  parameter int SYNC_STAGES = 2
) (
  input  logic                                        src_clk_i,
  input  logic                                        src_rst_ni,
  input  cdc_clear_pkg::clear_ctrl_t                  ctrl_i,
  input  cdc_fifo_pkg::payload_t                      src_data_i,
  input  logic                                        src_valid_i,
  output logic                                        src_ready_o,
  output cdc_fifo_pkg::payload_t [2**LOG_DEPTH-1:0]   async_data_o,
  output logic [LOG_DEPTH:0]                          async_wptr_o,
  input  logic [LOG_DEPTH:0]                          async_rptr_i
);

  // pointers carry one wrap bit above the slot address
  localparam int PTR_W = LOG_DEPTH + 1;
  // in gray code a full FIFO shows up as the top two bits inverted
  localparam logic [PTR_W-1:0] GRAY_FULL = PTR_W'(3) << (LOG_DEPTH - 1);

  cdc_fifo_pkg::payload_t [2**LOG_DEPTH-1:0] data_q;
  logic [PTR_W-1:0] wptr_bin_q;
  logic [PTR_W-1:0] wptr_bin_next;
  logic [PTR_W-1:0] wptr_gray_q;
  logic [PTR_W-1:0] rptr_sync;
  logic             full;
  logic             write_en;

  // read pointer from the destination domain
  cdc_sync_bits #(
    .STAGES ( SYNC_STAGES ),
    .WIDTH  ( PTR_W       )
  ) i_sync_rptr (
    .clk_i   ( src_clk_i    ),
    .rst_ni  ( src_rst_ni   ),
    .async_i ( async_rptr_i ),
    .sync_o  ( rptr_sync    )
  );

  // same as the binary pointers differing only in their top bit
  assign full        = (wptr_gray_q ^ rptr_sync) == GRAY_FULL;
  assign src_ready_o = ~full & ~ctrl_i.isolate;
  assign write_en    = src_valid_i & src_ready_o;

  assign wptr_bin_next = wptr_bin_q + 1'b1;

  // the gray pointer is a register so the crossing never sees a glitch
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else if (ctrl_i.clear) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else if (write_en) begin
      wptr_bin_q  <= wptr_bin_next;
      wptr_gray_q <= wptr_bin_next ^ (wptr_bin_next >> 1);
    end
  end

  // a slot is written in the transfer cycle and read later in the other domain
  always_ff @(posedge src_clk_i) begin
    if (write_en) begin
      data_q[wptr_bin_q[LOG_DEPTH-1:0]] <= src_data_i;
    end
  end

  assign async_data_o = data_q;
  assign async_wptr_o = wptr_gray_q;

endmodule

/* cdc_fifo/cdc_fifo_dst.sv */
/*
 * destination half of the clock domain crossing FIFO, clocked by dst_clk_i
 * a slot is only read once the synchronized write pointer has passed it
 * the spill register adds one cycle of latency and cuts the ready path
 */
module cdc_fifo_dst #(
  parameter int LOG_DEPTH   = 3,
  parameter int SYNC_STAGES = 2
) (
  input  logic                                      dst_clk_i,
  input  logic                                      dst_rst_ni,
  input  cdc_clear_pkg::clear_ctrl_t                ctrl_i,
  input  cdc_fifo_pkg::payload_t [2**LOG_DEPTH-1:0] async_data_i,
  input  logic [LOG_DEPTH:0]                        async_wptr_i,
  output logic [LOG_DEPTH:0]                        async_rptr_o,
  output cdc_fifo_pkg::payload_t                    dst_data_o,
  output logic                                      dst_valid_o,
  input  logic                                      dst_ready_i
);

  localparam int PTR_W = LOG_DEPTH + 1;

  logic [PTR_W-1:0] rptr_bin_q;
  logic [PTR_W-1:0] rptr_bin_next;
  logic [PTR_W-1:0] rptr_gray_q;
  logic [PTR_W-1:0] wptr_sync;
  logic             fifo_valid;
  logic             spill_ready;
  logic             spill_valid;
  logic             read_en;

  // write pointer from the source domain
  cdc_sync_bits #(
    .STAGES ( SYNC_STAGES ),
    .WIDTH  ( PTR_W       )
  ) i_sync_wptr (
    .clk_i   ( dst_clk_i    ),
    .rst_ni  ( dst_rst_ni   ),
    .async_i ( async_wptr_i ),
    .sync_o  ( wptr_sync    )
  );

  // equal gray pointers mean empty
  // while isolated the pointer view may be stale, so nothing enters the spill register
  assign fifo_valid = (rptr_gray_q != wptr_sync) & ~ctrl_i.isolate;
  assign read_en    = fifo_valid & spill_ready;

  assign rptr_bin_next = rptr_bin_q + 1'b1;

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      rptr_bin_q  <= '0;
      rptr_gray_q <= '0;
    end else if (ctrl_i.clear) begin
      rptr_bin_q  <= '0;
      rptr_gray_q <= '0;
    end else if (read_en) begin
      rptr_bin_q  <= rptr_bin_next;
      rptr_gray_q <= rptr_bin_next ^ (rptr_bin_next >> 1);
    end
  end

  assign async_rptr_o = rptr_gray_q;

  // the read mux runs entirely in this domain
  spill_register_flushable i_spill_register (
    .clk_i   ( dst_clk_i                           ),
    .rst_ni  ( dst_rst_ni                          ),
    .flush_i ( ctrl_i.clear                        ),
    .valid_i ( fifo_valid                          ),
    .ready_o ( spill_ready                         ),
    .data_i  ( async_data_i[rptr_bin_q[LOG_DEPTH-1:0]] ),
    .valid_o ( spill_valid                         ),
    .ready_i ( dst_ready_i & ~ctrl_i.isolate       ),
    .data_o  ( dst_data_o                          )
  );

  // held words stay hidden during isolation and are flushed by the clear
  assign dst_valid_o = spill_valid & ~ctrl_i.isolate;

endmodule

/* cdc_clear/cdc_clear_ctrl.sv */
/*
 * two-domain clear sequencer for the clock domain crossing FIFO
 * a one-cycle clear request on either side runs both sides through
 * isolate, clear and release in lock-step
 * both asynchronous resets are expected to be applied together
 * a request that arrives while a sequence runs merges into it
 */
module cdc_clear_ctrl #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                       src_clk_i,
  input  logic                       src_rst_ni,
  input  logic                       src_clear_i,
  output cdc_clear_pkg::clear_ctrl_t src_ctrl_o,
  output logic                       src_clear_pending_o,
  input  logic                       dst_clk_i,
  input  logic                       dst_rst_ni,
  input  logic                       dst_clear_i,
  output cdc_clear_pkg::clear_ctrl_t dst_ctrl_o,
  output logic                       dst_clear_pending_o
);

  cdc_clear_pkg::clear_phase_e src_phase_q;
  cdc_clear_pkg::clear_phase_e src_phase_d;
  cdc_clear_pkg::clear_phase_e dst_phase_q;
  cdc_clear_pkg::clear_phase_e dst_phase_d;
  // each side's phase as seen from the other clock domain
  logic [1:0]                  dst_phase_in_src;
  logic [1:0]                  src_phase_in_dst;

  // one step of the shared phase machine
  // a side only moves on once it sees the other side in the matching phase
  function automatic cdc_clear_pkg::clear_phase_e next_phase(
    input cdc_clear_pkg::clear_phase_e cur,
    input logic [1:0]                  remote,
    input logic                        req
  );
    cdc_clear_pkg::clear_phase_e nxt;
    nxt = cur;
    case (cur)
      // start on a local request or when the other side has started
      cdc_clear_pkg::PHASE_IDLE: begin
        if (req || remote == cdc_clear_pkg::PHASE_ISOLATE) begin
          nxt = cdc_clear_pkg::PHASE_ISOLATE;
        end
      end
      // clear only when both sides are known to be isolated
      cdc_clear_pkg::PHASE_ISOLATE: begin
        if (remote == cdc_clear_pkg::PHASE_ISOLATE || remote == cdc_clear_pkg::PHASE_CLEAR) begin
          nxt = cdc_clear_pkg::PHASE_CLEAR;
        end
      end
      // the other side has cleared its pointers once it shows clear or release
      cdc_clear_pkg::PHASE_CLEAR: begin
        if (remote == cdc_clear_pkg::PHASE_CLEAR || remote == cdc_clear_pkg::PHASE_RELEASE) begin
          nxt = cdc_clear_pkg::PHASE_RELEASE;
        end
      end
      // the other side's cleared pointer crosses with the same delay as its phase,
      // so once it has left clear the synchronized pointer is settled
      default: begin
        if (remote != cdc_clear_pkg::PHASE_CLEAR) begin
          nxt = cdc_clear_pkg::PHASE_IDLE;
        end
      end
    endcase
    return nxt;
  endfunction

  // the gray phase encoding makes each crossing a single-bit change
  cdc_sync_bits #(
    .STAGES ( SYNC_STAGES ),
    .WIDTH  ( 2           )
  ) i_sync_dst_phase (
    .clk_i   ( src_clk_i        ),
    .rst_ni  ( src_rst_ni       ),
    .async_i ( dst_phase_q      ),
    .sync_o  ( dst_phase_in_src )
  );

  cdc_sync_bits #(
    .STAGES ( SYNC_STAGES ),
    .WIDTH  ( 2           )
  ) i_sync_src_phase (
    .clk_i   ( dst_clk_i        ),
    .rst_ni  ( dst_rst_ni       ),
    .async_i ( src_phase_q      ),
    .sync_o  ( src_phase_in_dst )
  );

  assign src_phase_d = next_phase(src_phase_q, dst_phase_in_src, src_clear_i);
  assign dst_phase_d = next_phase(dst_phase_q, src_phase_in_dst, dst_clear_i);

  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      src_phase_q <= cdc_clear_pkg::PHASE_IDLE;
    end else begin
      src_phase_q <= src_phase_d;
    end
  end

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      dst_phase_q <= cdc_clear_pkg::PHASE_IDLE;
    end else begin
      dst_phase_q <= dst_phase_d;
    end
  end

  // isolation covers the whole sequence and clear sits in the middle of it
  assign src_ctrl_o.isolate = src_phase_q != cdc_clear_pkg::PHASE_IDLE;
  assign src_ctrl_o.clear   = src_phase_q == cdc_clear_pkg::PHASE_CLEAR;
  assign dst_ctrl_o.isolate = dst_phase_q != cdc_clear_pkg::PHASE_IDLE;
  assign dst_ctrl_o.clear   = dst_phase_q == cdc_clear_pkg::PHASE_CLEAR;

  // pending rises the cycle after the request and falls when release is done
  assign src_clear_pending_o = src_ctrl_o.isolate;
  assign dst_clear_pending_o = dst_ctrl_o.isolate;

endmodule

/* verilog/cdc_fifo_top.sv */
/*
 * clock domain crossing FIFO with one-sided synchronous clear
 * LOG_DEPTH must be at least 1 and SYNC_STAGES at least 2
 * data, write pointer and read pointer cross without timing constraints here
 */
module cdc_fifo_top #(
  parameter int LOG_DEPTH   = cdc_fifo_pkg::LOG_DEPTH_DEFAULT,
  parameter int SYNC_STAGES = cdc_fifo_pkg::SYNC_STAGES_DEFAULT
) (
  input  logic                   src_clk_i,
  input  logic                   src_rst_ni,
  input  logic                   src_clear_i,
  output logic                   src_clear_pending_o,
  input  cdc_fifo_pkg::payload_t src_data_i,
  input  logic                   src_valid_i,
  output logic                   src_ready_o,
  input  logic                   dst_clk_i,
  input  logic                   dst_rst_ni,
  input  logic                   dst_clear_i,
  output logic                   dst_clear_pending_o,
  output cdc_fifo_pkg::payload_t dst_data_o,
  output logic                   dst_valid_o,
  input  logic                   dst_ready_i
);

  // signals between the two halves that cross clock domains
  cdc_fifo_pkg::payload_t [2**LOG_DEPTH-1:0] async_data;
  logic [LOG_DEPTH:0]                        async_wptr;
  logic [LOG_DEPTH:0]                        async_rptr;
  cdc_clear_pkg::clear_ctrl_t                src_ctrl;
  cdc_clear_pkg::clear_ctrl_t                dst_ctrl;

  cdc_fifo_src #(
    .LOG_DEPTH   ( LOG_DEPTH   ),
    .SYNC_STAGES ( SYNC_STAGES )
  ) i_cdc_fifo_src (
    .src_clk_i    ( src_clk_i   ),
    .src_rst_ni   ( src_rst_ni  ),
    .ctrl_i       ( src_ctrl    ),
    .src_data_i   ( src_data_i  ),
    .src_valid_i  ( src_valid_i ),
    .src_ready_o  ( src_ready_o ),
    .async_data_o ( async_data  ),
    .async_wptr_o ( async_wptr  ),
    .async_rptr_i ( async_rptr  )
  );

  cdc_fifo_dst #(
    .LOG_DEPTH   ( LOG_DEPTH   ),
    .SYNC_STAGES ( SYNC_STAGES )
  ) i_cdc_fifo_dst (
    .dst_clk_i    ( dst_clk_i   ),
    .dst_rst_ni   ( dst_rst_ni  ),
    .ctrl_i       ( dst_ctrl    ),
    .async_data_i ( async_data  ),
    .async_wptr_i ( async_wptr  ),
    .async_rptr_o ( async_rptr  ),
    .dst_data_o   ( dst_data_o  ),
    .dst_valid_o  ( dst_valid_o ),
    .dst_ready_i  ( dst_ready_i )
  );

  cdc_clear_ctrl #(
    .SYNC_STAGES ( SYNC_STAGES )
  ) i_cdc_clear_ctrl (
    .src_clk_i           ( src_clk_i           ),
    .src_rst_ni          ( src_rst_ni          ),
    .src_clear_i         ( src_clear_i         ),
    .src_ctrl_o          ( src_ctrl            ),
    .src_clear_pending_o ( src_clear_pending_o ),
    .dst_clk_i           ( dst_clk_i           ),
    .dst_rst_ni          ( dst_rst_ni          ),
    .dst_clear_i         ( dst_clear_i         ),
    .dst_ctrl_o          ( dst_ctrl            ),
    .dst_clear_pending_o ( dst_clear_pending_o )
  );

endmodule

/* verif/cdc_fifo_checker.sv */
/*
 * concurrent assertions bound into the FIFO top level
 * the clear phases are taken from the sequencer instance inside the top level
 */
module cdc_fifo_checker (
  input logic                        src_clk_i,
  input logic                        src_rst_ni,
  input logic                        src_valid_i,
  input logic                        src_ready_o,
  input cdc_fifo_pkg::payload_t      src_data_i,
  input logic                        src_clear_pending_o,
  input logic                        dst_clk_i,
  input logic                        dst_rst_ni,
  input logic                        dst_valid_o,
  input logic                        dst_ready_i,
  input cdc_fifo_pkg::payload_t      dst_data_o,
  input logic                        dst_clear_pending_o,
  input cdc_clear_pkg::clear_phase_e src_phase_i,
  input cdc_clear_pkg::clear_phase_e dst_phase_i
);

  // an offered source word stays unchanged until taken unless a clear intervenes
  src_hold_a: assert property (@(posedge src_clk_i) disable iff (!src_rst_ni)
    (src_valid_i && !src_ready_o) |=>
      (src_clear_pending_o || (src_valid_i && $stable(src_data_i))))
    else $error("source word changed or was withdrawn before it was taken");

  // a delivered word stays on the output until the destination takes it
  dst_hold_a: assert property (@(posedge dst_clk_i) disable iff (!dst_rst_ni)
    (dst_valid_o && !dst_ready_i) |=>
      (dst_clear_pending_o || (dst_valid_o && $stable(dst_data_o))))
    else $error("destination word changed or vanished before it was taken");

  src_isolated_a: assert property (@(posedge src_clk_i) disable iff (!src_rst_ni)
    src_clear_pending_o |-> !src_ready_o)
    else $error("source accepted words while its clear was pending");

  // a side resets its pointers only while the other side is still isolated
  src_clear_a: assert property (@(posedge src_clk_i) disable iff (!src_rst_ni)
    (src_phase_i == cdc_clear_pkg::PHASE_CLEAR) |->
      (dst_phase_i != cdc_clear_pkg::PHASE_IDLE))
    else $error("source cleared its pointers while the destination was not isolated");

  dst_clear_a: assert property (@(posedge dst_clk_i) disable iff (!dst_rst_ni)
    (dst_phase_i == cdc_clear_pkg::PHASE_CLEAR) |->
      (src_phase_i != cdc_clear_pkg::PHASE_IDLE))
    else $error("destination cleared its pointers while the source was not isolated");

endmodule

bind cdc_fifo_top cdc_fifo_checker i_cdc_fifo_checker (
  .src_clk_i           ( src_clk_i                    ),
  .src_rst_ni          ( src_rst_ni                   ),
  .src_valid_i         ( src_valid_i                  ),
  .src_ready_o         ( src_ready_o                  ),
  .src_data_i          ( src_data_i                   ),
  .src_clear_pending_o ( src_clear_pending_o          ),
  .dst_clk_i           ( dst_clk_i                    ),
  .dst_rst_ni          ( dst_rst_ni                   ),
  .dst_valid_o         ( dst_valid_o                  ),
  .dst_ready_i         ( dst_ready_i                  ),
  .dst_data_o          ( dst_data_o                   ),
  .dst_clear_pending_o ( dst_clear_pending_o          ),
  .src_phase_i         ( i_cdc_clear_ctrl.src_phase_q ),
  .dst_phase_i         ( i_cdc_clear_ctrl.dst_phase_q )
);

/* verif/tb_cdc_fifo.sv */
/*
 * testbench for the clock domain crossing FIFO with random traffic from a fixed seed
 * a queue model records every accepted source word and each delivery must match its head
 * a clear drops every outstanding word
 * the model is emptied when the source side leaves its clear sequence
 */
module tb_cdc_fifo;

  localparam int LOG_DEPTH    = cdc_fifo_pkg::LOG_DEPTH_DEFAULT;
  localparam int SYNC_STAGES  = cdc_fifo_pkg::SYNC_STAGES_DEFAULT;
  localparam int DEPTH        = 2 ** LOG_DEPTH;
  localparam int READY_RANDOM = 0;
  localparam int READY_HOLD   = 1;
  localparam int READY_ALWAYS = 2;

  logic                   src_clk_i;
  logic                   src_rst_ni;
  logic                   src_clear_i;
  logic                   src_clear_pending_o;
  cdc_fifo_pkg::payload_t src_data_i;
  logic                   src_valid_i;
  logic                   src_ready_o;
  logic                   dst_clk_i;
  logic                   dst_rst_ni;
  logic                   dst_clear_i;
  logic                   dst_clear_pending_o;
  cdc_fifo_pkg::payload_t dst_data_o;
  logic                   dst_valid_o;
  logic                   dst_ready_i;

  integer                 seed = 32'hd2a7;
  cdc_fifo_pkg::payload_t model[$];
  // stimulus knobs set by the main sequence and read by the two drivers
  bit                     drivers_on;
  bit                     src_on;
  int                     src_rate;
  int                     dst_mode;
  // source driver state carried from one falling edge to the next
  bit                     src_taken;
  bit                     src_pend_seen;
  int                     accepted;
  int                     delivered;

  cdc_fifo_top #(
    .LOG_DEPTH   ( LOG_DEPTH   ),
    .SYNC_STAGES ( SYNC_STAGES )
  ) i_cdc_fifo_top (
    .src_clk_i           ( src_clk_i           ),
    .src_rst_ni          ( src_rst_ni          ),
    .src_clear_i         ( src_clear_i         ),
    .src_clear_pending_o ( src_clear_pending_o ),
    .src_data_i          ( src_data_i          ),
    .src_valid_i         ( src_valid_i         ),
    .src_ready_o         ( src_ready_o         ),
    .dst_clk_i           ( dst_clk_i           ),
    .dst_rst_ni          ( dst_rst_ni          ),
    .dst_clear_i         ( dst_clear_i         ),
    .dst_clear_pending_o ( dst_clear_pending_o ),
    .dst_data_o          ( dst_data_o          ),
    .dst_valid_o         ( dst_valid_o         ),
    .dst_ready_i         ( dst_ready_i         )
  );

  initial begin
    dst_clk_i = 1'b0;
    forever #10 dst_clk_i = ~dst_clk_i;
  end

  // unrelated period so that the edges of the two domains drift against each other
  initial begin
    src_clk_i = 1'b0;
    forever #7 src_clk_i = ~src_clk_i;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // runs on every falling source edge
  // src_ready_o only changes on a rising edge, so the coming transfer is known here
  task automatic drive_source();
    logic [31:0] rnd;
    if (src_pend_seen && !src_clear_pending_o) begin
      model.delete();
    end
    src_pend_seen = src_clear_pending_o;
    if (src_clear_pending_o) begin
      compare_value("src_ready_o", 32'(src_ready_o), 32'd0);
    end
    // an offered word is held until it is taken
    if (!src_valid_i || src_taken) begin
      rnd = $random(seed);
      src_valid_i = src_on && (int'(rnd[6:0]) < src_rate);
      rnd = $random(seed);
      src_data_i = rnd[19:0];
    end
    src_taken = src_valid_i && src_ready_o;
    if (src_taken) begin
      model.push_back(src_data_i);
      accepted++;
    end
  endtask

  // dst_valid_o and dst_data_o come from flops and are settled at the falling edge
  task automatic drive_destination();
    logic [31:0]            rnd;
    cdc_fifo_pkg::payload_t expected;
    rnd = $random(seed);
    case (dst_mode)
      READY_HOLD:   dst_ready_i = 1'b0;
      READY_ALWAYS: dst_ready_i = 1'b1;
      default:      dst_ready_i = rnd[3:0] < 4'd9;
    endcase
    if (dst_valid_o && dst_ready_i) begin
      if (model.size() == 0) begin
        stop_on_error("a word was delivered although no accepted word was outstanding");
      end
      expected = model.pop_front();
      compare_value("dst_data_o", 32'(dst_data_o), 32'(expected));
      delivered++;
    end
  endtask

  initial begin
    forever begin
      @(negedge src_clk_i);
      if (drivers_on) begin
        drive_source();
      end
    end
  end

  initial begin
    forever begin
      @(negedge dst_clk_i);
      if (drivers_on) begin
        drive_destination();
      end
    end
  end

  task automatic wait_for_deliveries(input int count);
    int cycles;
    cycles = 0;
    while (delivered < count) begin
      if (cycles == 20000) begin
        stop_on_error("timeout while waiting for random traffic to deliver words");
      end
      @(negedge dst_clk_i);
      cycles++;
    end
  endtask

  // stops new source words and reads until every accepted word has come out
  task automatic drain_fifo();
    int cycles;
    cycles = 0;
    src_on = 1'b0;
    dst_mode = READY_ALWAYS;
    while (model.size() != 0 || src_valid_i || dst_valid_o) begin
      if (cycles == 2000) begin
        stop_on_error("timeout while draining the FIFO, accepted words never came out");
      end
      @(negedge dst_clk_i);
      cycles++;
    end
  endtask

  // the spill register takes two words beyond the FIFO slots before ready stays low
  task automatic fill_until_full();
    int cycles;
    int low_run;
    cycles = 0;
    low_run = 0;
    src_on = 1'b1;
    src_rate = 128;
    dst_mode = READY_HOLD;
    while (low_run < 16) begin
      if (cycles == 1000) begin
        stop_on_error("timeout: src_ready_o did not stay low while the destination stalled");
      end
      @(negedge src_clk_i);
      low_run = src_ready_o ? 0 : low_run + 1;
      cycles++;
    end
    if (model.size() > DEPTH + 2) begin
      stop_on_error("the source accepted more words than the FIFO and spill register hold");
    end
  endtask

  task automatic request_src_clear();
    @(negedge src_clk_i);
    src_clear_i = 1'b1;
    @(negedge src_clk_i);
    src_clear_i = 1'b0;
    compare_value("src_clear_pending_o", 32'(src_clear_pending_o), 32'd1);
  endtask

  task automatic request_dst_clear();
    @(negedge dst_clk_i);
    dst_clear_i = 1'b1;
    @(negedge dst_clk_i);
    dst_clear_i = 1'b0;
    compare_value("dst_clear_pending_o", 32'(dst_clear_pending_o), 32'd1);
  endtask

  task automatic wait_for_clear_end();
    int cycles;
    cycles = 0;
    while (src_clear_pending_o || dst_clear_pending_o) begin
      if (cycles == 500) begin
        stop_on_error("timeout: a clear sequence never finished on both sides");
      end
      @(negedge dst_clk_i);
      cycles++;
    end
  endtask

  initial begin
    int          round;
    int          gap;
    logic [31:0] rnd;
    src_rst_ni    = 1'b0;
    dst_rst_ni    = 1'b0;
    src_clear_i   = 1'b0;
    dst_clear_i   = 1'b0;
    src_valid_i   = 1'b0;
    src_data_i    = '0;
    dst_ready_i   = 1'b0;
    drivers_on    = 1'b0;
    src_on        = 1'b0;
    src_rate      = 64;
    dst_mode      = READY_RANDOM;
    src_taken     = 1'b0;
    src_pend_seen = 1'b0;
    accepted      = 0;
    delivered     = 0;
    repeat (16) @(posedge dst_clk_i);
    @(negedge dst_clk_i);
    dst_rst_ni = 1'b1;
    @(negedge src_clk_i);
    src_rst_ni = 1'b1;

    // an empty FIFO right after reset
    @(negedge src_clk_i);
    compare_value("src_ready_o", 32'(src_ready_o), 32'd1);
    compare_value("src_clear_pending_o", 32'(src_clear_pending_o), 32'd0);
    @(negedge dst_clk_i);
    compare_value("dst_valid_o", 32'(dst_valid_o), 32'd0);
    compare_value("dst_clear_pending_o", 32'(dst_clear_pending_o), 32'd0);

    drivers_on = 1'b1;
    src_on = 1'b1;
    wait_for_deliveries(300);
    drain_fifo();

    // back-pressure then resumed reading
    fill_until_full();
    drain_fifo();

    // source, destination and nearly simultaneous clears under random traffic
    for (round = 0; round < 12; round++) begin
      src_on = 1'b1;
      src_rate = 64;
      dst_mode = READY_RANDOM;
      rnd = $random(seed);
      repeat (10 + int'(rnd[5:0])) @(negedge dst_clk_i);
      gap = int'(rnd[9:8]) % 3;
      case (round % 3)
        0: request_src_clear();
        1: request_dst_clear();
        default: begin
          fork
            request_src_clear();
            begin
              repeat (gap) @(negedge dst_clk_i);
              request_dst_clear();
            end
          join
        end
      endcase
      wait_for_clear_end();
    end

    src_on = 1'b1;
    dst_mode = READY_RANDOM;
    wait_for_deliveries(delivered + 100);
    drain_fifo();
    $display("%0d words accepted and %0d delivered", accepted, delivered);
    $display("TEST OK");
    $finish;
  end

endmodule

/* compile.f */
common/cdc_fifo_pkg.sv
common/cdc_clear_pkg.sv
verilog/cdc_sync_bits.sv
verilog/spill_register_flushable.sv
cdc_fifo/cdc_fifo_src.sv
cdc_fifo/cdc_fifo_dst.sv
cdc_clear/cdc_clear_ctrl.sv
verilog/cdc_fifo_top.sv
verif/cdc_fifo_checker.sv
verif/tb_cdc_fifo.sv

/* run.sh */
#!/bin/sh
# builds the clock domain crossing FIFO testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cdc_fifo \
  -f compile.f

./obj_dir/Vtb_cdc_fifo
